// File: logic/lsu_pkg.sv
// load-store package with widths, access and fault encodings, request/response structs
`default_nettype none

package lsu_pkg;

    // data path and address widths
    localparam int XLEN = 64;
    localparam int ADDR_W = 32;

    // access size carried with each request
    typedef enum logic [1:0] {
        width_byte  = 2'd0,
        width_half  = 2'd1,
        width_word  = 2'd2,
        width_dword = 2'd3
    } access_width_e;

    // outcome reported with every response
    typedef enum logic [1:0] {
        fault_none       = 2'd0,
        fault_misaligned = 2'd1,
        fault_range      = 2'd2
    } fault_e;

    // one load or store from the requester
    typedef struct packed {
        logic                 write;
        access_width_e        width;
        logic                 load_unsigned;
        logic [ADDR_W-1:0]    addr;
        logic [XLEN-1:0]      wdata;
    } mem_req_t;

    // one response, rdata is zero for stores and faulted requests
    typedef struct packed {
        logic            write;
        fault_e          fault;
        logic [XLEN-1:0] rdata;
    } mem_rsp_t;

    // doubleword seen whole or as eight byte lanes
    typedef union packed {
        logic [XLEN-1:0]   whole;
        logic [7:0][7:0]   bytes;
    } dword_u;

endpackage

`default_nettype wire

// File: logic/credit_counter.sv
// response credit counter, counts down on each response and up on each returned credit
`default_nettype none

module credit_counter #(
    parameter int RSP_CREDITS = 2
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic credit_take,
    input  wire logic credit_return,
    output logic      credit_avail
);

    localparam int CNT_W = $clog2(RSP_CREDITS + 1);
    localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(RSP_CREDITS);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= CNT_FULL;
        end else begin
            // take and return together cancel out
            if (credit_take && !credit_return) begin
                count <= count - 1'b1;
            end else if (credit_return && !credit_take) begin
                count <= count + 1'b1;
            end
        end
    end

    assign credit_avail = (count != '0);

    // consumer side must never go below zero
    assert property (@(posedge clk) disable iff (!rst_n) credit_take |-> count != '0)
        else $error("credit taken with none left");

    // requester returns more credits than it was given
    assert property (@(posedge clk) disable iff (!rst_n)
        credit_return && !credit_take |-> count != CNT_FULL)
        else $error("credit returned while counter is full");

endmodule

`default_nettype wire

// File: logic/store_aligner.sv
// store aligner, turns width and low address into byte enables, lane data and a misalign flag
`default_nettype none

module store_aligner (
    input  wire logic [2:0]               addr_low,
    input  wire lsu_pkg::access_width_e   width,
    input  wire logic [lsu_pkg::XLEN-1:0] wdata,
    output logic [7:0]                    byte_en,
    output lsu_pkg::dword_u               lane_data,
    output logic                          misaligned
);

    logic [7:0]      base_en;
    logic [2:0]      size_mask;
    lsu_pkg::dword_u src;

    // enables for an access at lane 0, and the address bits that must be clear
    always_comb begin
        unique case (width)
            lsu_pkg::width_byte: begin
                base_en   = 8'h01;
                size_mask = 3'b000;
            end
            lsu_pkg::width_half: begin
                base_en   = 8'h03;
                size_mask = 3'b001;
            end
            lsu_pkg::width_word: begin
                base_en   = 8'h0f;
                size_mask = 3'b011;
            end
            default: begin
                base_en   = 8'hff;
                size_mask = 3'b111;
            end
        endcase
    end

    assign misaligned = |(addr_low & size_mask);
    assign byte_en    = base_en << addr_low;
    assign src.whole  = wdata;

    // lane i takes source byte i - offset
    always_comb begin : place_lanes
        logic [2:0] src_lane;
        for (int i = 0; i < 8; i++) begin
            src_lane = 3'(i) - addr_low;
            if (byte_en[i]) begin
                lane_data.bytes[i] = src.bytes[src_lane];
            end else begin
                lane_data.bytes[i] = 8'h00;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/data_ram.sv
// doubleword RAM with per-byte write enables and a one-cycle registered read
`default_nettype none

module data_ram #(
    parameter int RAM_DEPTH_LOG2 = 10
) (
    input  wire logic                      clk,
    input  wire logic [RAM_DEPTH_LOG2-1:0] index,
    input  wire logic                      wen,
    input  wire logic                      ren,
    input  wire logic [7:0]                byte_en,
    input  wire lsu_pkg::dword_u           wdata,
    output lsu_pkg::dword_u                rdata
);

    localparam int DEPTH = 2 ** RAM_DEPTH_LOG2;

    logic [lsu_pkg::XLEN-1:0] mem [DEPTH];

    // byte-masked write
    always_ff @(posedge clk) begin
        if (wen) begin
            for (int b = 0; b < 8; b++) begin
                if (byte_en[b]) begin
                    mem[index][b*8 +: 8] <= wdata.whole[b*8 +: 8];
                end
            end
        end
    end

    // read register holds its value until the next read
    always_ff @(posedge clk) begin
        if (ren) begin
            rdata.whole <= mem[index];
        end
    end

endmodule

`default_nettype wire

// File: logic/load_extractor.sv
// load extractor, shifts the addressed lanes down and zero- or sign-extends to 64 bits
`default_nettype none

module load_extractor (
    input  wire logic [2:0]             addr_low,
    input  wire lsu_pkg::access_width_e width,
    input  wire logic                   load_unsigned,
    input  wire lsu_pkg::dword_u        rdata,
    output logic [lsu_pkg::XLEN-1:0]    load_data
);

    lsu_pkg::dword_u shifted;
    logic            sign;

    // rotate so the addressed lane lands at byte 0
    always_comb begin : shift_lanes
        logic [2:0] src_lane;
        for (int i = 0; i < 8; i++) begin
            src_lane = 3'(i) + addr_low;
            shifted.bytes[i] = rdata.bytes[src_lane];
        end
    end

    // top bit of the accessed field, cleared for unsigned loads
    always_comb begin
        unique case (width)
            lsu_pkg::width_byte: sign = shifted.bytes[0][7];
            lsu_pkg::width_half: sign = shifted.bytes[1][7];
            lsu_pkg::width_word: sign = shifted.bytes[3][7];
            default:             sign = shifted.bytes[7][7];
        endcase
        sign = sign & !load_unsigned;
    end

    always_comb begin
        unique case (width)
            lsu_pkg::width_byte: begin
                load_data = {{56{sign}}, shifted.bytes[0]};
            end
            lsu_pkg::width_half: begin
                load_data = {{48{sign}}, shifted.whole[15:0]};
            end
            lsu_pkg::width_word: begin
                load_data = {{32{sign}}, shifted.whole[31:0]};
            end
            default: begin
                // doubleword passes through untouched
                load_data = shifted.whole;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: logic/lsu_ctrl_fsm.sv
// request sequencer that holds one request, decides its fault, steps RAM and issues the response
`default_nettype none

module lsu_ctrl_fsm #(
    parameter logic [lsu_pkg::ADDR_W-1:0] RAM_BASE = 32'h8000_0000,
    parameter int RAM_DEPTH_LOG2 = 10
) (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     req_valid,
    input  wire lsu_pkg::mem_req_t        req,
    input  wire logic                     misaligned,
    input  wire logic                     credit_avail,
    input  wire logic [lsu_pkg::XLEN-1:0] load_data,
    output lsu_pkg::mem_req_t             hold_req,
    output logic [RAM_DEPTH_LOG2-1:0]     ram_index,
    output logic                          ram_wen,
    output logic                          ram_ren,
    output logic                          credit_take,
    output logic                          req_credit,
    output logic                          rsp_valid,
    output lsu_pkg::mem_rsp_t             rsp
);

    localparam int unsigned WIN_BYTES = 8 * (2 ** RAM_DEPTH_LOG2);
    // one extra bit so the window end cannot wrap
    localparam logic [lsu_pkg::ADDR_W:0] RAM_END =
        {1'b0, RAM_BASE} + (lsu_pkg::ADDR_W + 1)'(WIN_BYTES);

    typedef enum logic [1:0] {
        state_idle,
        state_access,
        state_respond
    } state_e;

    state_e                      state;
    lsu_pkg::fault_e             access_fault;
    lsu_pkg::fault_e             rsp_fault;
    logic                        out_of_range;
    logic [lsu_pkg::ADDR_W-1:0]  offset;

    assign out_of_range = (hold_req.addr < RAM_BASE) || ({1'b0, hold_req.addr} >= RAM_END);

    // range wins over alignment
    assign access_fault = out_of_range ? lsu_pkg::fault_range :
                          misaligned   ? lsu_pkg::fault_misaligned :
                                         lsu_pkg::fault_none;

    assign offset    = hold_req.addr - RAM_BASE;
    assign ram_index = offset[RAM_DEPTH_LOG2+2:3];

    // RAM only sees fault-free accesses
    assign ram_wen = (state == state_access) && (access_fault == lsu_pkg::fault_none)
                     && hold_req.write;
    assign ram_ren = (state == state_access) && (access_fault == lsu_pkg::fault_none)
                     && !hold_req.write;

    assign rsp_valid   = (state == state_respond) && credit_avail;
    assign req_credit  = rsp_valid;
    assign credit_take = rsp_valid;

    assign rsp.write = hold_req.write;
    assign rsp.fault = rsp_fault;
    assign rsp.rdata = (!hold_req.write && rsp_fault == lsu_pkg::fault_none) ?
                       load_data : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= state_idle;
        end else begin
            unique case (state)
                state_idle:    if (req_valid) state <= state_access;
                state_access:  state <= state_respond;
                state_respond: if (rsp_valid) state <= state_idle;
                default:       state <= state_idle;
            endcase
        end
    end

    // request and fault payload
    always_ff @(posedge clk) begin
        if (state == state_idle && req_valid) begin
            hold_req <= req;
        end
        if (state == state_access) begin
            rsp_fault <= access_fault;
        end
    end

    // requester must hold the single credit to send
    assert property (@(posedge clk) disable iff (!rst_n) req_valid |-> state == state_idle)
        else $error("req_valid while a request is in flight");

    // credits only drop when a response takes one
    assert property (@(posedge clk) disable iff (!rst_n)
        credit_avail && !credit_take |=> credit_avail)
        else $error("response credits lost without a response");

endmodule

`default_nettype wire

// File: logic/lsu_top.sv
// data-memory subsystem top, wires the request FSM, credit counter, aligners and RAM
`default_nettype none

module lsu_top #(
    parameter logic [lsu_pkg::ADDR_W-1:0] RAM_BASE = 32'h8000_0000,
    parameter int RAM_DEPTH_LOG2 = 10,
    parameter int RSP_CREDITS = 2
) (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire logic             req_valid,
    input  wire lsu_pkg::mem_req_t req,
    output logic                  req_credit,
    output logic                  rsp_valid,
    output lsu_pkg::mem_rsp_t     rsp,
    input  wire logic             rsp_credit
);

    lsu_pkg::mem_req_t         hold_req;
    logic                      misaligned;
    logic                      credit_avail;
    logic                      credit_take;
    logic [lsu_pkg::XLEN-1:0]  load_data;
    logic [RAM_DEPTH_LOG2-1:0] ram_index;
    logic                      ram_wen;
    logic                      ram_ren;
    logic [7:0]                byte_en;
    lsu_pkg::dword_u           lane_data;
    lsu_pkg::dword_u           ram_rdata;

    lsu_ctrl_fsm #(
        .RAM_BASE       (RAM_BASE),
        .RAM_DEPTH_LOG2 (RAM_DEPTH_LOG2)
    ) u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid    (req_valid),
        .req          (req),
        .misaligned   (misaligned),
        .credit_avail (credit_avail),
        .load_data    (load_data),
        .hold_req     (hold_req),
        .ram_index    (ram_index),
        .ram_wen      (ram_wen),
        .ram_ren      (ram_ren),
        .credit_take  (credit_take),
        .req_credit   (req_credit),
        .rsp_valid    (rsp_valid),
        .rsp          (rsp)
    );

    credit_counter #(
        .RSP_CREDITS (RSP_CREDITS)
    ) u_credits (
        .clk           (clk),
        .rst_n         (rst_n),
        .credit_take   (credit_take),
        .credit_return (rsp_credit),
        .credit_avail  (credit_avail)
    );

    store_aligner u_store_align (
        .addr_low   (hold_req.addr[2:0]),
        .width      (hold_req.width),
        .wdata      (hold_req.wdata),
        .byte_en    (byte_en),
        .lane_data  (lane_data),
        .misaligned (misaligned)
    );

    data_ram #(
        .RAM_DEPTH_LOG2 (RAM_DEPTH_LOG2)
    ) u_ram (
        .clk     (clk),
        .index   (ram_index),
        .wen     (ram_wen),
        .ren     (ram_ren),
        .byte_en (byte_en),
        .wdata   (lane_data),
        .rdata   (ram_rdata)
    );

    load_extractor u_load_extract (
        .addr_low      (hold_req.addr[2:0]),
        .width         (hold_req.width),
        .load_unsigned (hold_req.load_unsigned),
        .rdata         (ram_rdata),
        .load_data     (load_data)
    );

endmodule

`default_nettype wire

// File: verification/lsu_checker.sv
// response checker, mirrors byte memory from observed requests and compares every response
`default_nettype none

module lsu_checker #(
    parameter logic [lsu_pkg::ADDR_W-1:0] RAM_BASE = 32'h8000_0000,
    parameter int RAM_DEPTH_LOG2 = 10,
    parameter int RSP_CREDITS = 2
) (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              req_valid,
    input  wire lsu_pkg::mem_req_t req,
    input  wire logic              req_credit,
    input  wire logic              rsp_valid,
    input  wire lsu_pkg::mem_rsp_t rsp,
    input  wire logic              rsp_credit,
    output int                     err_count,
    output int                     pending
);

    // first byte address past the window
    localparam logic [63:0] WIN_END = {32'd0, RAM_BASE} + (64'd8 << RAM_DEPTH_LOG2);

    logic [7:0]        model_mem [logic [31:0]];
    lsu_pkg::mem_rsp_t expect_q [$];
    int                errors = 0;
    int                credits;

    function automatic lsu_pkg::mem_rsp_t predict(input lsu_pkg::mem_req_t r);
        lsu_pkg::mem_rsp_t p;
        int                size;
        p = '0;
        p.write = r.write;
        size = 1 << r.width;
        if ({32'd0, r.addr} < {32'd0, RAM_BASE} || {32'd0, r.addr} >= WIN_END) begin
            p.fault = lsu_pkg::fault_range;
        end else if (r.addr % size != 0) begin
            p.fault = lsu_pkg::fault_misaligned;
        end else if (!r.write) begin
            // little endian gather, then extend from the top bit of the field
            for (int b = 0; b < size; b++) begin
                p.rdata[8*b +: 8] = model_mem[r.addr + 32'(b)];
            end
            if (!r.load_unsigned && size < 8 && p.rdata[8*size-1]) begin
                p.rdata = p.rdata | ~((64'd1 << (8 * size)) - 64'd1);
            end
        end
        return p;
    endfunction

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        errors++;
    endtask

    always @(posedge clk) begin : watch
        lsu_pkg::mem_rsp_t exp;
        if (!rst_n) begin
            expect_q.delete();
            credits = RSP_CREDITS;
        end else begin
            if (rsp_valid !== req_credit) begin
                report_failure("req_credit did not follow rsp_valid");
            end
            if (rsp_valid) begin
                if (credits == 0) begin
                    report_failure("response issued with no response credit left");
                end
                credits--;
                if (expect_q.size() == 0) begin
                    report_failure("extra response with no request outstanding");
                end else begin
                    exp = expect_q.pop_front();
                    compare("rsp.write", 64'(rsp.write), 64'(exp.write));
                    compare("rsp.fault", 64'(rsp.fault), 64'(exp.fault));
                    compare("rsp.rdata", rsp.rdata, exp.rdata);
                end
            end
            if (rsp_credit) begin
                credits++;
            end
            if (req_valid) begin
                exp = predict(req);
                expect_q.push_back(exp);
                // only a fault-free store changes memory
                if (req.write && exp.fault == lsu_pkg::fault_none) begin
                    for (int b = 0; b < (1 << req.width); b++) begin
                        model_mem[req.addr + 32'(b)] = req.wdata[8*b +: 8];
                    end
                end
            end
        end
        err_count <= errors;
        pending   <= expect_q.size();
    end

endmodule

`default_nettype wire

// File: verification/lsu_tb.sv
// testbench for the data-memory subsystem driving random loads and stores under credit back-pressure
`default_nettype none

module lsu_tb;

    localparam logic [31:0] RAM_BASE = 32'h8000_0000;
    localparam int DEPTH_LOG2 = 10;
    localparam int RSP_CREDITS = 2;
    localparam logic [31:0] WIN_BYTES = 32'(8 << DEPTH_LOG2);
    localparam int NUM_REQS = 400;
    localparam int FILL_REQS = 32;
    localparam int CYCLE_LIMIT = NUM_REQS * 20 + 200;

    logic              clk;
    logic              rst_n;
    logic              req_valid;
    lsu_pkg::mem_req_t req;
    logic              req_credit;
    logic              rsp_valid;
    lsu_pkg::mem_rsp_t rsp;
    logic              rsp_credit;

    logic [31:0] lfsr = 32'hcf9f_5b29;
    int          credit_delays [$];
    int          rsp_seen = 0;
    int          credits_given = 0;
    int          cycles = 0;
    int          err_count;
    int          pending;

    lsu_top #(
        .RAM_BASE       (RAM_BASE),
        .RAM_DEPTH_LOG2 (DEPTH_LOG2),
        .RSP_CREDITS    (RSP_CREDITS)
    ) uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .req_credit (req_credit),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .rsp_credit (rsp_credit)
    );

    lsu_checker #(
        .RAM_BASE       (RAM_BASE),
        .RAM_DEPTH_LOG2 (DEPTH_LOG2),
        .RSP_CREDITS    (RSP_CREDITS)
    ) u_checker (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .req_credit (req_credit),
        .rsp_valid  (rsp_valid),
        .rsp        (rsp),
        .rsp_credit (rsp_credit),
        .err_count  (err_count),
        .pending    (pending)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[62:0], lfsr[0]};
        end
    endtask

    task automatic random_req(output lsu_pkg::mem_req_t r);
        logic [63:0] bits;
        logic [7:0]  offset;
        take_bits(4, bits);
        r.write         = bits[3];
        r.width         = lsu_pkg::access_width_e'(bits[2:1]);
        r.load_unsigned = bits[0];
        take_bits(10, bits);
        offset = bits[7:0];
        // three in four requests are aligned to their size
        if (bits[9:8] != 2'd0) begin
            offset = offset & ~8'((1 << r.width) - 1);
        end
        take_bits(4, bits);
        if (bits[3:0] == 4'd0) begin
            r.addr = RAM_BASE - 32'd256 + 32'(offset);
        end else if (bits[3:0] == 4'd1) begin
            r.addr = RAM_BASE + WIN_BYTES + 32'(offset);
        end else begin
            r.addr = RAM_BASE + 32'(offset);
        end
        take_bits(64, bits);
        r.wdata = bits;
    endtask

    // present one request and hold until the request credit comes back
    task automatic send_req(input lsu_pkg::mem_req_t r);
        req_valid <= 1'b1;
        req       <= r;
        @(posedge clk);
        req_valid <= 1'b0;
        while (!req_credit) begin
            @(posedge clk);
        end
    endtask

    always @(posedge clk) begin
        if (rst_n && rsp_valid) begin
            rsp_seen <= rsp_seen + 1;
        end
    end

    // one credit back per response after its own delay
    initial begin : credit_return
        int delay;
        rsp_credit <= 1'b0;
        forever begin
            @(posedge clk);
            rsp_credit <= 1'b0;
            if (rst_n && credits_given < rsp_seen) begin
                delay = credit_delays.pop_front();
                repeat (delay) @(posedge clk);
                rsp_credit <= 1'b1;
                credits_given++;
            end
        end
    end

    initial begin : stimulus
        lsu_pkg::mem_req_t r;
        logic [63:0]       bits;
        rst_n     <= 1'b0;
        req_valid <= 1'b0;
        req       <= '0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        // idle stretch after reset before the first request
        repeat (6) @(posedge clk);
        for (int i = 0; i < NUM_REQS; i++) begin
            if (i < FILL_REQS) begin
                // fill every doubleword of the region before any load
                take_bits(64, bits);
                r = '{write: 1'b1, width: lsu_pkg::width_dword, load_unsigned: 1'b0,
                      addr: RAM_BASE + 32'(i * 8), wdata: bits};
            end else begin
                random_req(r);
            end
            take_bits(3, bits);
            credit_delays.push_back(int'(bits % 7));
            send_req(r);
        end
        while (credits_given < rsp_seen) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("error counts: %0d checker errors, %0d missing responses", err_count, pending);
        if (err_count == 0 && pending == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("error counts: %0d checker errors, %0d missing responses",
                     err_count, pending);
            $display("TEST FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: files.f
logic/lsu_pkg.sv
logic/credit_counter.sv
logic/store_aligner.sv
logic/data_ram.sv
logic/load_extractor.sv
logic/lsu_ctrl_fsm.sv
logic/lsu_top.sv
verification/lsu_checker.sv
verification/lsu_tb.sv
